/* lenet_pkg.sv */
package lenet_pkg;

    // number format and accumulator
    localparam int data_width  = 16;
    localparam int frac_bits   = 8;
    localparam int acc_width   = 40;

    // layer sizes
    localparam int n_in        = 16;
    localparam int n_hidden    = 8;
    localparam int n_class     = 10;
    localparam int index_width = 4;

    localparam int param_depth = 256;
    localparam int feat_depth  = 64;

    typedef logic [7:0] param_addr_t;
    typedef logic [5:0] feat_addr_t;

    // bias first, then the weights of each neuron
    localparam param_addr_t fc1_param_base = 8'd0;
    localparam param_addr_t fc2_param_base = 8'd136;

    localparam feat_addr_t feat_in_base     = 6'd0;
    localparam feat_addr_t feat_hidden_base = 6'd16;
    localparam feat_addr_t feat_out_base    = 6'd24;

    typedef logic signed [data_width-1:0] act_t;
    typedef logic signed [data_width-1:0] weight_t;
    typedef logic signed [acc_width-1:0]  acc_t;
    typedef logic [index_width-1:0]       class_idx_t;

    typedef enum logic {stage_fc1, stage_fc2} stage_t;

    // apb byte addresses
    localparam logic [11:0] reg_ctrl     = 12'h000;
    localparam logic [11:0] reg_status   = 12'h004;
    localparam logic [11:0] param_window = 12'h400;
    localparam logic [11:0] feat_window  = 12'h800;

endpackage

/* word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
    parameter type word_t = lenet_pkg::act_t,
    parameter int depth = lenet_pkg::feat_depth,
    parameter int addr_width = $clog2(depth)
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [addr_width-1:0] waddr,
    input  word_t                 wdata,
    input  logic [addr_width-1:0] raddr,
    output word_t                 rdata
);

    word_t mem [depth];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];
    end

    write_in_range: assert property (@(posedge clk)
        we |-> (!$isunknown(waddr) && (int'(waddr) < depth)));

endmodule

/* layer_sequencer.sv */
`timescale 1ns/1ps

module layer_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              layer_issued,
    input  logic              layer_written,
    input  logic              max_valid,
    output logic              busy,
    output logic              done,
    output logic              fc1_done,
    output logic              fc2_done,
    output logic              layer_go,
    output lenet_pkg::stage_t stage
);

    import lenet_pkg::*;

    typedef enum logic [2:0] {s_idle, s_fc1, s_fc2, s_finish, s_done} seq_state_t;

    seq_state_t state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= s_idle;
            busy     <= 1'b0;
            done     <= 1'b0;
            fc1_done <= 1'b0;
            fc2_done <= 1'b0;
            layer_go <= 1'b0;
            stage    <= stage_fc1;
        end
        else
        begin
            layer_go <= 1'b0;
            case (state)
                s_idle, s_done:
                begin
                    if (start)
                    begin
                        busy     <= 1'b1;
                        done     <= 1'b0;
                        fc1_done <= 1'b0;
                        fc2_done <= 1'b0;
                        layer_go <= 1'b1;
                        stage    <= stage_fc1;
                        state    <= s_fc1;
                    end
                end
                s_fc1:
                begin
                    // hidden layer fully in memory, launch fc2
                    if (layer_written)
                    begin
                        fc1_done <= 1'b1;
                        layer_go <= 1'b1;
                        stage    <= stage_fc2;
                        state    <= s_fc2;
                    end
                end
                s_fc2:
                begin
                    if (layer_written)
                    begin
                        fc2_done <= 1'b1;
                        state    <= s_finish;
                    end
                end
                s_finish:
                begin
                    if (max_valid)
                    begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= s_done;
                    end
                end
                default:
                begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // counter must be idle before the next layer starts
    go_after_issue: assert property (@(posedge clk) disable iff (rst)
        layer_go |=> (!layer_go until layer_issued));

endmodule

/* mac_counter.sv */
`timescale 1ns/1ps

module mac_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   layer_go,
    input  lenet_pkg::stage_t      stage,
    output lenet_pkg::param_addr_t param_raddr,
    output lenet_pkg::feat_addr_t  feat_raddr,
    output logic                   tap_valid,
    output logic                   tap_first,
    output logic                   tap_last,
    output lenet_pkg::class_idx_t  neuron_idx,
    output logic                   layer_issued
);

    import lenet_pkg::*;

    logic        active;
    logic [4:0]  tap_cnt;
    class_idx_t  neuron_cnt;
    logic [4:0]  fan_in;
    class_idx_t  last_neuron;
    param_addr_t stride;
    param_addr_t param_base;
    feat_addr_t  src_base;

    always_comb
    begin
        if (stage == stage_fc1)
        begin
            fan_in      = 5'(n_in);
            last_neuron = class_idx_t'(n_hidden - 1);
            stride      = param_addr_t'(n_in + 1);
            param_base  = fc1_param_base;
            src_base    = feat_in_base;
        end
        else
        begin
            fan_in      = 5'(n_hidden);
            last_neuron = class_idx_t'(n_class - 1);
            stride      = param_addr_t'(n_hidden + 1);
            param_base  = fc2_param_base;
            src_base    = feat_hidden_base;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            active     <= 1'b0;
            tap_cnt    <= '0;
            neuron_cnt <= '0;
        end
        else if (layer_go)
        begin
            active     <= 1'b1;
            tap_cnt    <= '0;
            neuron_cnt <= '0;
        end
        else if (active)
        begin
            if (tap_cnt == fan_in)
            begin
                tap_cnt <= '0;
                if (neuron_cnt == last_neuron)
                    active <= 1'b0;
                else
                    neuron_cnt <= neuron_cnt + 1'b1;
            end
            else
            begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    // tap 0 is the bias word, taps 1..fan_in pair weight and activation
    assign param_raddr  = param_base + neuron_cnt * stride + tap_cnt;
    assign feat_raddr   = (tap_cnt == '0) ? src_base : src_base + tap_cnt - 1'b1;
    assign tap_valid    = active;
    assign tap_first    = active && (tap_cnt == '0);
    assign tap_last     = active && (tap_cnt == fan_in);
    assign neuron_idx   = neuron_cnt;
    assign layer_issued = tap_last && (neuron_cnt == last_neuron);

    tap_in_range: assert property (@(posedge clk) disable iff (rst)
        tap_valid |-> (tap_cnt <= fan_in));

endmodule

/* neuron_mac.sv */
`timescale 1ns/1ps

module neuron_mac (
    input  logic                  clk,
    input  logic                  rst,
    input  lenet_pkg::stage_t     stage,
    input  logic                  tap_valid,
    input  logic                  tap_first,
    input  logic                  tap_last,
    input  lenet_pkg::class_idx_t neuron_idx,
    input  lenet_pkg::weight_t    weight,
    input  lenet_pkg::act_t       act,
    output logic                  feat_we,
    output lenet_pkg::feat_addr_t feat_waddr,
    output lenet_pkg::act_t       feat_wdata,
    output logic                  layer_written,
    output logic                  score_we,
    output lenet_pkg::class_idx_t score_idx
);

    import lenet_pkg::*;

    logic                           v1;
    logic                           first1;
    logic                           last1;
    class_idx_t                     idx1;
    logic                           wb;
    class_idx_t                     wb_idx;
    acc_t                           acc;
    logic signed [2*data_width-1:0] prod;
    acc_t                           shifted;
    act_t                           sat;

    // tags delayed one cycle to meet the ram data
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            v1     <= 1'b0;
            first1 <= 1'b0;
            last1  <= 1'b0;
            idx1   <= '0;
            wb     <= 1'b0;
            wb_idx <= '0;
        end
        else
        begin
            v1     <= tap_valid;
            first1 <= tap_first;
            last1  <= tap_last;
            idx1   <= neuron_idx;
            wb     <= v1 && last1;
            if (v1 && last1)
                wb_idx <= idx1;
        end
    end

    assign prod = weight * act;

    always_ff @(posedge clk)
    begin
        if (v1)
            acc <= first1 ? (acc_t'(weight) <<< frac_bits) : acc + prod;
    end

    always_comb
    begin
        shifted = acc >>> frac_bits;
        // clip to q8.8 when the upper bits are not a sign extension
        if (shifted[acc_width-1:data_width-1] != {(acc_width-data_width+1){shifted[acc_width-1]}})
            sat = shifted[acc_width-1] ? {1'b1, {(data_width-1){1'b0}}}
                                       : {1'b0, {(data_width-1){1'b1}}};
        else
            sat = shifted[data_width-1:0];
    end

    // relu only on the hidden layer
    assign feat_wdata    = (stage == stage_fc1 && sat[data_width-1]) ? '0 : sat;
    assign feat_we       = wb;
    assign feat_waddr    = ((stage == stage_fc1) ? feat_hidden_base : feat_out_base) + wb_idx;
    assign layer_written = wb && (wb_idx == ((stage == stage_fc1) ? class_idx_t'(n_hidden - 1)
                                                                   : class_idx_t'(n_class - 1)));
    assign score_we      = wb && (stage == stage_fc2);
    assign score_idx     = wb_idx;

endmodule

/* argmax_unit.sv */
`timescale 1ns/1ps

module argmax_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  score_we,
    input  lenet_pkg::act_t       score,
    input  lenet_pkg::class_idx_t score_idx,
    output lenet_pkg::class_idx_t max_index,
    output logic                  max_valid
);

    import lenet_pkg::*;

    act_t max_score;
    logic take;

    // strictly greater keeps the lowest index on ties
    assign take = score_we && (score_idx == '0 || score > max_score);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            max_index <= '0;
            max_valid <= 1'b0;
        end
        else if (start)
        begin
            max_valid <= 1'b0;
        end
        else
        begin
            if (take)
                max_index <= score_idx;
            if (score_we && score_idx == class_idx_t'(n_class - 1))
                max_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
            max_score <= score;
    end

endmodule

/* apb_host_bridge.sv */
`timescale 1ns/1ps

module apb_host_bridge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [11:0]            paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   busy,
    input  logic                   done,
    input  logic                   fc1_done,
    input  logic                   fc2_done,
    input  lenet_pkg::class_idx_t  max_index,
    output logic                   start,
    input  lenet_pkg::param_addr_t param_raddr_eng,
    input  lenet_pkg::feat_addr_t  feat_raddr_eng,
    input  logic                   feat_we_eng,
    input  lenet_pkg::feat_addr_t  feat_waddr_eng,
    input  lenet_pkg::act_t        feat_wdata_eng,
    output logic                   param_we,
    output lenet_pkg::param_addr_t param_waddr,
    output lenet_pkg::weight_t     param_wdata,
    output lenet_pkg::param_addr_t param_raddr,
    output logic                   feat_we,
    output lenet_pkg::feat_addr_t  feat_waddr,
    output lenet_pkg::act_t        feat_wdata,
    output lenet_pkg::feat_addr_t  feat_raddr,
    input  lenet_pkg::weight_t     param_rdata,
    input  lenet_pkg::act_t        feat_rdata
);

    import lenet_pkg::*;

    logic        access;
    logic        is_ctrl;
    logic        is_status;
    logic        is_param;
    logic        is_feat;
    logic        is_mem;
    logic        err;
    logic        mem_rd;
    logic        rd_wait;
    logic        wr_ok;
    logic        correct;
    logic        wrong;
    class_idx_t  label;
    param_addr_t apb_param_addr;
    feat_addr_t  apb_feat_addr;

    assign access    = psel && penable;
    assign is_ctrl   = (paddr == reg_ctrl);
    assign is_status = (paddr == reg_status);
    assign is_param  = (paddr >= param_window) && (paddr < param_window + 4 * param_depth);
    assign is_feat   = (paddr >= feat_window) && (paddr < feat_window + 4 * feat_depth);
    assign is_mem    = is_param || is_feat;

    // memories belong to the engine during a run
    assign err = !(is_ctrl || is_status || is_mem) || (is_mem && busy) || (is_status && pwrite);

    // ram reads take one wait state
    assign mem_rd  = is_mem && !pwrite && !err;
    assign pready  = access && (!mem_rd || rd_wait);
    assign pslverr = pready && err;
    assign wr_ok   = access && pwrite && !err;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_wait <= 1'b0;
            start   <= 1'b0;
            label   <= '0;
        end
        else
        begin
            rd_wait <= access && mem_rd && !rd_wait;
            start   <= wr_ok && is_ctrl && pwdata[0] && !busy;
            if (wr_ok && is_ctrl)
                label <= pwdata[7:4];
        end
    end

    assign correct = done && (label == max_index);
    assign wrong   = done && (label != max_index);

    always_comb
    begin
        prdata = '0;
        if (is_ctrl)
            prdata[7:4] = label;
        else if (is_status)
            prdata = {20'b0, max_index, 2'b0, wrong, correct, fc2_done, fc1_done, done, busy};
        else if (is_param && !err)
            prdata[15:0] = param_rdata;
        else if (is_feat && !err)
            prdata[15:0] = feat_rdata;
    end

    assign apb_param_addr = paddr[9:2];
    assign apb_feat_addr  = paddr[7:2];

    assign param_we    = wr_ok && is_param;
    assign param_waddr = apb_param_addr;
    assign param_wdata = weight_t'(pwdata[15:0]);
    assign param_raddr = busy ? param_raddr_eng : apb_param_addr;

    assign feat_we    = busy ? feat_we_eng : (wr_ok && is_feat);
    assign feat_waddr = busy ? feat_waddr_eng : apb_feat_addr;
    assign feat_wdata = busy ? feat_wdata_eng : act_t'(pwdata[15:0]);
    assign feat_raddr = busy ? feat_raddr_eng : apb_feat_addr;

endmodule

/* lenet_top.sv */
`timescale 1ns/1ps

module lenet_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    import lenet_pkg::*;

    logic        start;
    logic        busy;
    logic        done;
    logic        fc1_done;
    logic        fc2_done;
    logic        layer_go;
    logic        layer_issued;
    logic        layer_written;
    logic        max_valid;
    stage_t      stage;
    logic        tap_valid;
    logic        tap_first;
    logic        tap_last;
    class_idx_t  neuron_idx;
    class_idx_t  max_index;
    class_idx_t  score_idx;
    logic        score_we;
    param_addr_t param_raddr_eng;
    feat_addr_t  feat_raddr_eng;
    logic        feat_we_eng;
    feat_addr_t  feat_waddr_eng;
    act_t        feat_wdata_eng;
    logic        param_we;
    param_addr_t param_waddr;
    weight_t     param_wdata;
    param_addr_t param_raddr;
    weight_t     param_rdata;
    logic        feat_we;
    feat_addr_t  feat_waddr;
    act_t        feat_wdata;
    feat_addr_t  feat_raddr;
    act_t        feat_rdata;

    apb_host_bridge u_bridge (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .busy(busy), .done(done), .fc1_done(fc1_done), .fc2_done(fc2_done),
        .max_index(max_index), .start(start),
        .param_raddr_eng(param_raddr_eng), .feat_raddr_eng(feat_raddr_eng),
        .feat_we_eng(feat_we_eng), .feat_waddr_eng(feat_waddr_eng),
        .feat_wdata_eng(feat_wdata_eng),
        .param_we(param_we), .param_waddr(param_waddr), .param_wdata(param_wdata),
        .param_raddr(param_raddr),
        .feat_we(feat_we), .feat_waddr(feat_waddr), .feat_wdata(feat_wdata),
        .feat_raddr(feat_raddr),
        .param_rdata(param_rdata), .feat_rdata(feat_rdata)
    );

    layer_sequencer u_seq (
        .clk(clk), .rst(rst), .start(start),
        .layer_issued(layer_issued), .layer_written(layer_written), .max_valid(max_valid),
        .busy(busy), .done(done), .fc1_done(fc1_done), .fc2_done(fc2_done),
        .layer_go(layer_go), .stage(stage)
    );

    mac_counter u_cnt (
        .clk(clk), .rst(rst), .layer_go(layer_go), .stage(stage),
        .param_raddr(param_raddr_eng), .feat_raddr(feat_raddr_eng),
        .tap_valid(tap_valid), .tap_first(tap_first), .tap_last(tap_last),
        .neuron_idx(neuron_idx), .layer_issued(layer_issued)
    );

    neuron_mac u_mac (
        .clk(clk), .rst(rst), .stage(stage),
        .tap_valid(tap_valid), .tap_first(tap_first), .tap_last(tap_last),
        .neuron_idx(neuron_idx), .weight(param_rdata), .act(feat_rdata),
        .feat_we(feat_we_eng), .feat_waddr(feat_waddr_eng), .feat_wdata(feat_wdata_eng),
        .layer_written(layer_written), .score_we(score_we), .score_idx(score_idx)
    );

    argmax_unit u_argmax (
        .clk(clk), .rst(rst), .start(start),
        .score_we(score_we), .score(feat_wdata_eng), .score_idx(score_idx),
        .max_index(max_index), .max_valid(max_valid)
    );

    word_ram #(.word_t(weight_t), .depth(param_depth)) param_mem (
        .clk(clk), .we(param_we), .waddr(param_waddr), .wdata(param_wdata),
        .raddr(param_raddr), .rdata(param_rdata)
    );

    word_ram #(.word_t(act_t), .depth(feat_depth)) feat_mem (
        .clk(clk), .we(feat_we), .waddr(feat_waddr), .wdata(feat_wdata),
        .raddr(feat_raddr), .rdata(feat_rdata)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* tb_lenet.sv */
`timescale 1ns/1ps

module tb_lenet;

    import lenet_pkg::*;

    // a full run of all tests needs roughly 4000 cycles
    localparam int max_cycles   = 20000;
    localparam int sample_delay = 10;
    localparam int param_used   = 136 + 10 * 9;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          checks;
    int          cycles = 0;
    logic [15:0] lfsr;
    int          p_mem [param_depth];
    int          in_vec [n_in];
    int          exp_hidden [n_hidden];
    int          exp_score [n_class];
    int          exp_max;
    string       current_test;

    tb_clock_gen #(.period(40), .reset_cycles(2)) u_clk (.clk(clk), .rst(rst));

    lenet_top dut0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= max_cycles)
        begin
            $display("run stopped, no result after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // q8.8 value within +-2.0
    function automatic int random_q88();
        int v;
        v = random_bits(10);
        if (v >= 512)
            v -= 1024;
        return v;
    endfunction

    function automatic logic [11:0] param_word_addr(input int i);
        return param_window + 12'(4 * i);
    endfunction

    function automatic logic [11:0] feat_word_addr(input int i);
        return feat_window + 12'(4 * i);
    endfunction

    // param window followed directly by the feature window
    function automatic bit in_mem_window(input logic [11:0] addr);
        return (addr >= param_window) && (int'(addr) < int'(feat_window) + 4 * feat_depth);
    endfunction

    function automatic int signed_word(input logic [31:0] d);
        return int'($signed(d[15:0]));
    endfunction

    function automatic int saturate_q88(input longint acc, input bit relu);
        longint v;
        v = acc >>> frac_bits;
        if (v > 32767)
            v = 32767;
        if (v < -32768)
            v = -32768;
        if (relu && v < 0)
            v = 0;
        return int'(v);
    endfunction

    task automatic compute_model();
        longint acc;
        int     base;
        for (int j = 0; j < n_hidden; j++)
        begin
            base = int'(fc1_param_base) + j * (n_in + 1);
            acc = longint'(p_mem[base]) * 256;
            for (int i = 0; i < n_in; i++)
                acc += longint'(p_mem[base + 1 + i]) * longint'(in_vec[i]);
            exp_hidden[j] = saturate_q88(acc, 1'b1);
        end
        exp_max = 0;
        for (int k = 0; k < n_class; k++)
        begin
            base = int'(fc2_param_base) + k * (n_hidden + 1);
            acc = longint'(p_mem[base]) * 256;
            for (int j = 0; j < n_hidden; j++)
                acc += longint'(p_mem[base + 1 + j]) * longint'(exp_hidden[j]);
            exp_score[k] = saturate_q88(acc, 1'b0);
            if (exp_score[k] > exp_score[exp_max])
                exp_max = k;
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("** Error [%s] expected %0d, got %0d", name, expected, actual);
        end
    endtask

    task automatic bus_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        int exp_waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #(sample_delay);
        while (!pready)
        begin
            @(negedge clk);
            #(sample_delay);
            waits++;
        end
        rdata = prdata;
        err   = pslverr;
        // one wait state for an accepted window read, none otherwise
        exp_waits = (!write && in_mem_window(addr) && !err) ? 1 : 0;
        check_value({current_test, " wait states"}, exp_waits, waits);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic load_memories();
        logic err;
        for (int i = 0; i < param_used; i++)
            apb_write(param_word_addr(i), 32'(p_mem[i] & 'hffff), err);
        for (int i = 0; i < n_in; i++)
            apb_write(feat_word_addr(int'(feat_in_base) + i), 32'(in_vec[i] & 'hffff), err);
        compute_model();
    endtask

    task automatic wait_done(output logic [31:0] status);
        logic err;
        status = '0;
        while (!status[1])
            apb_read(reg_status, status, err);
    endtask

    task automatic start_run(input int label, output logic [31:0] status);
        logic err;
        apb_write(reg_ctrl, 32'((label << 4) | 1), err);
        wait_done(status);
    endtask

    task automatic compare_results(input string name, input logic [31:0] status);
        logic [31:0] rd;
        logic        err;
        check_value({name, " busy"}, 0, int'(status[0]));
        check_value({name, " fc1_done"}, 1, int'(status[2]));
        check_value({name, " fc2_done"}, 1, int'(status[3]));
        check_value({name, " max_index"}, exp_max, int'(status[11:8]));
        for (int j = 0; j < n_hidden; j++)
        begin
            apb_read(feat_word_addr(int'(feat_hidden_base) + j), rd, err);
            check_value($sformatf("%s hidden %0d", name, j), exp_hidden[j], signed_word(rd));
        end
        for (int k = 0; k < n_class; k++)
        begin
            apb_read(feat_word_addr(int'(feat_out_base) + k), rd, err);
            check_value($sformatf("%s score %0d", name, k), exp_score[k], signed_word(rd));
        end
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        logic        err;
        current_test = "test_reset";
        apb_read(reg_ctrl, rd, err);
        check_value("test_reset ctrl", 0, int'(rd));
        check_value("test_reset ctrl pslverr", 0, int'(err));
        apb_read(reg_status, rd, err);
        check_value("test_reset status", 0, int'(rd));
        check_value("test_reset status pslverr", 0, int'(err));
    endtask

    task automatic test_mem_access();
        logic [31:0] rd;
        logic        err;
        int          idx;
        int          val;
        current_test = "test_mem_access";
        for (int i = 0; i < 4; i++)
        begin
            idx = random_bits(8);
            val = random_bits(16);
            apb_write(param_word_addr(idx), 32'(val), err);
            check_value("test_mem_access param write pslverr", 0, int'(err));
            apb_read(param_word_addr(idx), rd, err);
            check_value("test_mem_access param word", val, int'(rd[15:0]));
            idx = random_bits(6);
            val = random_bits(16);
            apb_write(feat_word_addr(idx), 32'(val), err);
            apb_read(feat_word_addr(idx), rd, err);
            check_value("test_mem_access feat word", val, int'(rd[15:0]));
        end
        apb_read(12'h100, rd, err);
        check_value("test_mem_access unmapped pslverr", 1, int'(err));
        apb_write(reg_status, 32'h1, err);
        check_value("test_mem_access status write pslverr", 1, int'(err));
        apb_read(reg_status, rd, err);
        check_value("test_mem_access status unchanged", 0, int'(rd));
    endtask

    task automatic test_inference();
        logic [31:0] status;
        current_test = "test_inference";
        for (int i = 0; i < param_used; i++)
            p_mem[i] = random_q88();
        for (int i = 0; i < n_in; i++)
            in_vec[i] = random_q88();
        load_memories();
        start_run(3, status);
        compare_results("test_inference", status);
    endtask

    task automatic test_label_check();
        logic [31:0] status;
        current_test = "test_label_check";
        start_run(exp_max, status);
        check_value("test_label_check correct", 1, int'(status[4]));
        check_value("test_label_check not wrong", 0, int'(status[5]));
        start_run((exp_max + 1) % n_class, status);
        check_value("test_label_check not correct", 0, int'(status[4]));
        check_value("test_label_check wrong", 1, int'(status[5]));
    endtask

    task automatic test_busy_guard();
        logic [31:0] rd;
        logic [31:0] status;
        logic        err;
        current_test = "test_busy_guard";
        apb_write(reg_ctrl, 32'h1, err);
        apb_read(reg_status, rd, err);
        check_value("test_busy_guard busy", 1, int'(rd[0]));
        apb_write(feat_word_addr(0), 32'h1234, err);
        check_value("test_busy_guard write pslverr", 1, int'(err));
        apb_read(param_word_addr(1), rd, err);
        check_value("test_busy_guard read pslverr", 1, int'(err));
        // second start lands in fc2, a restart would clear fc1_done
        rd = '0;
        while (!rd[2])
            apb_read(reg_status, rd, err);
        apb_write(reg_ctrl, 32'h1, err);
        check_value("test_busy_guard restart pslverr", 0, int'(err));
        apb_read(reg_status, rd, err);
        check_value("test_busy_guard fc1_done kept", 1, int'(rd[2]));
        wait_done(status);
        apb_read(feat_word_addr(0), rd, err);
        check_value("test_busy_guard input kept", in_vec[0], signed_word(rd));
        compare_results("test_busy_guard", status);
    endtask

    task automatic test_saturation_relu();
        logic [31:0] rd;
        logic [31:0] status;
        logic        err;
        int          fc2 [n_class];
        current_test = "test_saturation_relu";
        for (int i = 0; i < param_used; i++)
            p_mem[i] = 0;
        for (int i = 0; i < n_in; i++)
            in_vec[i] = 0;
        for (int k = 0; k < n_class; k++)
            fc2[k] = int'(fc2_param_base) + k * (n_hidden + 1);
        in_vec[0] = 32767;
        p_mem[0] = -256;
        p_mem[(n_in + 1) + 1] = 1024;
        // hidden 1 saturates, classes 2 and 5 tie at the top
        p_mem[fc2[0]] = -256;
        p_mem[fc2[2] + 2] = 1024;
        p_mem[fc2[5] + 2] = 1024;
        p_mem[fc2[7] + 2] = -1024;
        load_memories();
        start_run(2, status);
        apb_read(feat_word_addr(int'(feat_hidden_base)), rd, err);
        check_value("test_saturation_relu hidden 0 relu", 0, signed_word(rd));
        apb_read(feat_word_addr(int'(feat_hidden_base) + 1), rd, err);
        check_value("test_saturation_relu hidden 1 high", 32767, signed_word(rd));
        apb_read(feat_word_addr(int'(feat_out_base) + 2), rd, err);
        check_value("test_saturation_relu score 2 high", 32767, signed_word(rd));
        apb_read(feat_word_addr(int'(feat_out_base) + 7), rd, err);
        check_value("test_saturation_relu score 7 low", -32768, signed_word(rd));
        check_value("test_saturation_relu tie index", 2, int'(status[11:8]));
        compare_results("test_saturation_relu", status);
    endtask

    initial
    begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        lfsr    = 16'd10;
        @(negedge rst);
        test_reset();
        test_mem_access();
        test_inference();
        test_label_check();
        test_busy_guard();
        test_saturation_relu();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* src.f */
lenet_pkg.sv
word_ram.sv
layer_sequencer.sv
mac_counter.sv
neuron_mac.sv
argmax_unit.sv
apb_host_bridge.sv
lenet_top.sv
tb_clock_gen.sv
tb_lenet.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_lenet -o sim_lenet
./obj_dir/sim_lenet | tee sim.log

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1
